//--- Bender.yml
package:
  name: wb_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/wb_pkg.sv
      - design/write_back.sv
      - design/phy_regfile.sv
      - design/wb_log.sv
      - design/wb_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/wb_sva.sv
      - test/wb_tb.sv

//--- build.f
+incdir+include
design/wb_pkg.sv
design/write_back.sv
design/phy_regfile.sv
design/wb_log.sv
design/wb_core.sv
test/wb_sva.sv
test/wb_tb.sv

//--- design/phy_regfile.sv
//##########################################################
// physical register file
//##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module phy_regfile import wb_pkg::*; (
	input  logic     CLK,
	input  logic     rst_n,
	// next state from the write-back merge
	input  regfile_t regfile_d,
	// current state back to the merge
	output regfile_t regfile_q,
	// read address
	input  phy_idx_t rd_idx,
	// read data, combinational
	output xlen_t    rd_data
);

	// read hits one of the x0 copies
	logic rd_is_x0;

	// storage
	// every edge takes the merged next state
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			regfile_q <= '0;
		end else begin
			regfile_q <= regfile_d;

			// x0 guard, copies never hold data
			for (int unsigned p = 0; p < `WB_RP; p++) begin
				regfile_q[p] <= '0;
			end
		end
	end

	// upper bits of the index are the arch register
	assign rd_is_x0 = (rd_idx[5+`WB_RB-1:`WB_RB] == 5'd0);

	// read port
	// x0 copies return zero without looking at storage
	always_comb begin
		if (rd_is_x0) begin
			rd_data = '0;
		end else begin
			rd_data = regfile_q[rd_idx];
		end
	end

endmodule

`default_nettype wire

//--- design/wb_core.sv
//##########################################################
// write-back stage top
//##########################################################

`timescale 1ns/1ps
`default_nettype none

module wb_core import wb_pkg::*; (
	input  logic        CLK,
	input  logic        rst_n,
	// unit results
	// slots adder, logcmp, shift, jal, bru, lsu, csr
	input  wb_req_vec_t wb_req,
	// rename-side clear pulse
	input  logic        log_clr_valid,
	input  phy_idx_t    log_clr_rd,
	// shared read address for data and log
	input  phy_idx_t    rd_idx,
	output xlen_t       rd_data,
	output logic        rd_written,
	// full log view
	output phy_set_t    written
);

	// current register file, storage to merge
	regfile_t regfile_q;
	// next register file, merge to storage
	regfile_t regfile_d;
	// written set, merge to log
	phy_set_t wb_set;

	// combinational merge of the unit results
	write_back u_write_back (
		.wb_req    (wb_req),
		.regfile_q (regfile_q),
		.regfile_d (regfile_d),
		.wb_set    (wb_set)
	);

	// storage plus read port
	phy_regfile u_phy_regfile (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.regfile_d (regfile_d),
		.regfile_q (regfile_q),
		.rd_idx    (rd_idx),
		.rd_data   (rd_data)
	);

	// written bits
	// updates on the same edge as the storage
	wb_log u_wb_log (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.wb_set        (wb_set),
		.log_clr_valid (log_clr_valid),
		.log_clr_rd    (log_clr_rd),
		.rd_idx        (rd_idx),
		.rd_written    (rd_written),
		.written       (written)
	);

endmodule

`default_nettype wire

//--- design/wb_log.sv
//##########################################################
// write-back log
//##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module wb_log import wb_pkg::*; (
	input  logic     CLK,
	input  logic     rst_n,
	// registers written by write-back this cycle
	input  phy_set_t wb_set,
	// clear pulse from rename
	input  logic     log_clr_valid,
	input  phy_idx_t log_clr_rd,
	// lookup port
	input  phy_idx_t rd_idx,
	output logic     rd_written,
	// whole log
	output phy_set_t written
);

	// x0 copies sit in the low WB_RP bits
	localparam phy_set_t X0_MASK = phy_set_t'({`WB_RP{1'b1}});

	// stored bits
	phy_set_t log_q;
	// decoded clear pulse
	phy_set_t clr_mask;
	// next log state
	phy_set_t log_d;

	// one-hot of the register rename wants cleared
	always_comb begin
		clr_mask = '0;
		if (log_clr_valid) begin
			clr_mask[log_clr_rd] = 1'b1;
		end
	end

	// clear first, then set
	// so a same-cycle write-back keeps the bit up
	assign log_d = (log_q & ~clr_mask) | wb_set | X0_MASK;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			// x0 copies come out of reset already written
			log_q <= X0_MASK;
		end else begin
			log_q <= log_d;
		end
	end

	// whole log straight from storage
	assign written = log_q;

	// lookup
	assign rd_written = written[rd_idx];

endmodule

`default_nettype wire

//--- design/wb_pkg.sv
//##########################################################
// write-back types
//##########################################################

`default_nettype none

`include "wb_defs.svh"

package wb_pkg;

	// one integer data word
	typedef logic [`WB_XLEN-1:0] xlen_t;

	// physical index is {arch reg, copy}
	typedef logic [5+`WB_RB-1:0] phy_idx_t;

	// one result offered by an execution unit
	typedef struct packed {
		// strobe, no handshake behind it
		logic     valid;
		// renamed destination
		phy_idx_t rd;
		// result word
		xlen_t    res;
	} wb_req_t;

	// all units side by side, slot order follows unit_e
	typedef wb_req_t [`WB_UNITS-1:0] wb_req_vec_t;

	// whole physical register file as one vector
	typedef xlen_t [`WB_PHY_NUM-1:0] regfile_t;

	// one bit per physical register
	typedef logic [`WB_PHY_NUM-1:0] phy_set_t;

	// unit slots inside wb_req_vec_t
	typedef enum logic [2:0] {
		UNIT_ADDER  = 3'd0,
		UNIT_LOGCMP = 3'd1,
		UNIT_SHIFT  = 3'd2,
		UNIT_JAL    = 3'd3,
		UNIT_BRU    = 3'd4,
		UNIT_LSU    = 3'd5,
		UNIT_CSR    = 3'd6
	} unit_e;

endpackage

`default_nettype wire

//--- design/write_back.sv
//##########################################################
// write-back merge
//##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module write_back import wb_pkg::*; (
	// results from the seven units
	input  wb_req_vec_t wb_req,
	// current register file contents
	input  regfile_t    regfile_q,
	// next register file contents
	output regfile_t    regfile_d,
	// registers written this cycle
	output phy_set_t    wb_set
);

	// true when a request lands on physical register idx
	function automatic logic req_hits(input wb_req_t req, input int unsigned idx);
		logic hit;
		hit = req.valid && (req.rd == phy_idx_t'(idx));
		return hit;
	endfunction

	// per-register merge
	// units never share a destination, so an OR of the
	// matching results is the single result
	always_comb begin
		xlen_t merged;
		logic  any_hit;

		regfile_d = regfile_q;

		// x0 copies are hardwired zero
		for (int unsigned p = 0; p < `WB_RP; p++) begin
			regfile_d[p] = '0;
		end

		for (int unsigned p = `WB_RP; p < `WB_PHY_NUM; p++) begin
			merged  = '0;
			any_hit = 1'b0;

			for (int unsigned u = 0; u < `WB_UNITS; u++) begin
				// mask in this unit's result if it targets p
				merged  = merged | ({`WB_XLEN{req_hits(wb_req[u], p)}} & wb_req[u].res);
				any_hit = any_hit | req_hits(wb_req[u], p);
			end

			// nobody writes p, hold the old word
			if (any_hit) begin
				regfile_d[p] = merged;
			end
		end
	end

	// set vector for the write-back log
	// one bit per valid destination, x0 copies included,
	// the log pins those anyway
	always_comb begin
		wb_set = '0;

		for (int unsigned u = 0; u < `WB_UNITS; u++) begin
			if (wb_req[u].valid) begin
				wb_set[wb_req[u].rd] = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- include/wb_defs.svh
//##########################################################
// write-back sizing macros
//##########################################################

`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// integer data width
`define WB_XLEN 64

// renamed copies per architectural register
`define WB_RP 4

// bits needed to pick one copy
`define WB_RB 2

// 32 architectural registers, each with WB_RP copies
`define WB_PHY_NUM (32 * `WB_RP)

// adder, logcmp, shift, jal, bru, lsu, csr
`define WB_UNITS 7

`endif

//--- test/wb_sva.sv
//##########################################################
// write-back assertions
//##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module wb_sva import wb_pkg::*; (
	input logic        CLK,
	input logic        rst_n,
	input wb_req_vec_t wb_req,
	input phy_idx_t    rd_idx,
	input logic        rd_written,
	input phy_set_t    written
);

	// two valid slots aiming at one physical register
	function automatic logic rd_conflict(input wb_req_vec_t reqs);
		logic hit;
		hit = 1'b0;
		for (int a = 0; a < `WB_UNITS; a++) begin
			for (int b = a + 1; b < `WB_UNITS; b++) begin
				if (reqs[a].valid && reqs[b].valid && (reqs[a].rd == reqs[b].rd)) begin
					hit = 1'b1;
				end
			end
		end
		return hit;
	endfunction

	a_unique_rd: assert property (@(posedge CLK) disable iff (!rst_n)
		!rd_conflict(wb_req))
		else $error("two valid write-back requests share one destination");

	// per slot, log bit visible one cycle after the request
	for (genvar u = 0; u < `WB_UNITS; u++) begin : g_unit
		a_log_set: assert property (@(posedge CLK) disable iff (!rst_n)
			wb_req[u].valid |=> ((rd_idx != $past(wb_req[u].rd)) || rd_written))
			else $error("log bit not set after write-back from slot %0d", u);
	end

	// x0 copies pinned as written
	a_x0_written: assert property (@(posedge CLK) disable iff (!rst_n)
		&written[`WB_RP-1:0])
		else $error("x0 copy log bit reads not written");

endmodule

bind wb_core wb_sva u_sva (
	.CLK        (CLK),
	.rst_n      (rst_n),
	.wb_req     (wb_req),
	.rd_idx     (rd_idx),
	.rd_written (rd_written),
	.written    (written)
);

`default_nettype wire

//--- test/wb_tb.sv
//##########################################################
// write-back stage testbench
//##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "wb_defs.svh"

module wb_tb import wb_pkg::*; ();

	localparam time         CLK_PERIOD = 100;
	localparam time         DRIVE_DLY  = 1;
	localparam int unsigned RST_CYCLES = 8;
	localparam int unsigned RAND_CYCLES = 200;
	localparam int unsigned NUM_ROWS   = 12;
	localparam time         WATCHDOG   = 200000;
	localparam phy_set_t    X0_MASK    = phy_set_t'({`WB_RP{1'b1}});

	// one table row of stimulus plus expected read-back
	typedef struct packed {
		wb_req_vec_t reqs;
		logic        clr_valid;
		phy_idx_t    clr_rd;
		phy_idx_t    rd_idx;
		xlen_t       exp_data;
		logic        exp_written;
	} row_t;

	logic        CLK;
	logic        rst_n;
	wb_req_vec_t wb_req;
	logic        log_clr_valid;
	phy_idx_t    log_clr_rd;
	phy_idx_t    rd_idx;
	xlen_t       rd_data;
	logic        rd_written;
	phy_set_t    written;

	// reference state
	xlen_t       model_rf [`WB_PHY_NUM];
	phy_set_t    model_log;

	row_t        rows [NUM_ROWS];
	logic [31:0] lcg_state;

	wb_core u_dut (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.wb_req        (wb_req),
		.log_clr_valid (log_clr_valid),
		.log_clr_rd    (log_clr_rd),
		.rd_idx        (rd_idx),
		.rd_data       (rd_data),
		.rd_written    (rd_written),
		.written       (written)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// global guard against a stalled run
	initial begin
		#(WATCHDOG);
		$display("Test failures found");
		$fatal(1, "watchdog expired before the run finished");
	end

	function automatic logic [31:0] lcg_draw();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic wb_req_t make_req(input phy_idx_t rd, input xlen_t res);
		wb_req_t req;
		req.valid = 1'b1;
		req.rd    = rd;
		req.res   = res;
		return req;
	endfunction

	task automatic check_value(input string what, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s mismatch, got %h expected %h",
				$time, what, got, exp);
			$display("Test failures found");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Test failures found");
		$fatal(1, "timeout: %s", what);
	endtask

	// n rising edges, then the drive offset
	task wait_edges(input int unsigned n);
		int unsigned seen;
		seen = 0;
		while (seen < n) begin
			// one edge, or give up after two periods
			fork
				@(posedge CLK);
				begin
					#(2 * CLK_PERIOD);
					timeout_fail("clock edges did not arrive in time");
				end
			join_any
			disable fork;
			seen++;
		end
		#(DRIVE_DLY);
	endtask

	// clear before set, so a same-cycle write keeps the bit
	task automatic model_update(input wb_req_vec_t reqs, input logic clr_v,
			input phy_idx_t clr_rd);
		if (clr_v && (clr_rd >= `WB_RP)) begin
			model_log[clr_rd] = 1'b0;
		end
		for (int u = 0; u < `WB_UNITS; u++) begin
			if (reqs[u].valid) begin
				model_log[reqs[u].rd] = 1'b1;
				// x0 copies stay zero
				if (reqs[u].rd >= `WB_RP) begin
					model_rf[reqs[u].rd] = reqs[u].res;
				end
			end
		end
	endtask

	task automatic check_state();
		check_value("rd_data", rd_data, model_rf[rd_idx]);
		check_value("rd_written", rd_written, model_log[rd_idx]);
		check_value("written", written, model_log);
	endtask

	// drive one cycle, step the model at the edge, check after it
	task automatic apply_cycle(input wb_req_vec_t reqs, input logic clr_v,
			input phy_idx_t clr_rd, input phy_idx_t rd);
		wb_req        = reqs;
		log_clr_valid = clr_v;
		log_clr_rd    = clr_rd;
		rd_idx        = rd;
		wait_edges(1);
		model_update(reqs, clr_v, clr_rd);
		check_state();
		// pulses last one cycle
		wb_req        = '0;
		log_clr_valid = 1'b0;
	endtask

	task automatic set_row(input int i, input logic clr_v, input phy_idx_t clr_rd,
			input phy_idx_t rd, input xlen_t exp_d, input logic exp_w);
		rows[i].clr_valid   = clr_v;
		rows[i].clr_rd      = clr_rd;
		rows[i].rd_idx      = rd;
		rows[i].exp_data    = exp_d;
		rows[i].exp_written = exp_w;
	endtask

	task automatic fill_rows();
		for (int i = 0; i < NUM_ROWS; i++) begin
			rows[i] = '0;
		end
		// single adder write to x1 copy 1
		rows[0].reqs[UNIT_ADDER] = make_req(7'd5, 64'h0123_4567_89ab_cdef);
		set_row(0, 1'b0, 7'd0, 7'd5, 64'h0123_4567_89ab_cdef, 1'b1);
		// all seven units at once
		rows[1].reqs[UNIT_ADDER]  = make_req(7'd8, 64'ha000_0000_0000_0008);
		rows[1].reqs[UNIT_LOGCMP] = make_req(7'd13, 64'hb000_0000_0000_000d);
		rows[1].reqs[UNIT_SHIFT]  = make_req(7'd18, 64'hc000_0000_0000_0012);
		rows[1].reqs[UNIT_JAL]    = make_req(7'd23, 64'hd000_0000_0000_0017);
		rows[1].reqs[UNIT_BRU]    = make_req(7'd44, 64'he000_0000_0000_002c);
		rows[1].reqs[UNIT_LSU]    = make_req(7'd61, 64'hf000_0000_0000_003d);
		rows[1].reqs[UNIT_CSR]    = make_req(7'd127, 64'h1000_0000_0000_007f);
		set_row(1, 1'b0, 7'd0, 7'd8, 64'ha000_0000_0000_0008, 1'b1);
		set_row(2, 1'b0, 7'd0, 7'd127, 64'h1000_0000_0000_007f, 1'b1);
		set_row(3, 1'b0, 7'd0, 7'd44, 64'he000_0000_0000_002c, 1'b1);
		// earlier write untouched by the burst
		set_row(4, 1'b0, 7'd0, 7'd5, 64'h0123_4567_89ab_cdef, 1'b1);
		// x0 copies swallow data
		rows[5].reqs[UNIT_LSU] = make_req(7'd2, 64'hdead_beef_dead_beef);
		set_row(5, 1'b0, 7'd0, 7'd2, 64'h0, 1'b1);
		rows[6].reqs[UNIT_BRU] = make_req(7'd0, 64'hffff_ffff_ffff_ffff);
		rows[6].reqs[UNIT_JAL] = make_req(7'd3, 64'h0000_0000_0000_0001);
		set_row(6, 1'b0, 7'd0, 7'd0, 64'h0, 1'b1);
		// plain clear keeps the data
		set_row(7, 1'b1, 7'd5, 7'd5, 64'h0123_4567_89ab_cdef, 1'b0);
		// set beats clear on the same register
		rows[8].reqs[UNIT_SHIFT] = make_req(7'd13, 64'h5555_aaaa_5555_aaaa);
		set_row(8, 1'b1, 7'd13, 7'd13, 64'h5555_aaaa_5555_aaaa, 1'b1);
		// clear on an x0 copy is ignored
		set_row(9, 1'b1, 7'd2, 7'd2, 64'h0, 1'b1);
		rows[10].reqs[UNIT_LOGCMP] = make_req(7'd5, 64'h7777_0000_7777_0000);
		set_row(10, 1'b0, 7'd0, 7'd5, 64'h7777_0000_7777_0000, 1'b1);
		// never written
		set_row(11, 1'b0, 7'd0, 7'd6, 64'h0, 1'b0);
	endtask

	// random cycle with distinct destinations
	task automatic random_cycle();
		wb_req_vec_t reqs;
		phy_set_t    used;
		phy_idx_t    pick;
		phy_idx_t    rd;
		logic [31:0] r;
		int unsigned tries;
		reqs = '0;
		used = '0;
		rd   = phy_idx_t'(lcg_draw() >> 16);
		for (int u = 0; u < `WB_UNITS; u++) begin
			r = lcg_draw();
			if (r[19:16] < 4'd9) begin
				tries = 0;
				pick  = phy_idx_t'(lcg_draw() >> 16);
				while (used[pick] && (tries < 64)) begin
					pick = phy_idx_t'(lcg_draw() >> 16);
					tries++;
				end
				if (!used[pick]) begin
					used[pick] = 1'b1;
					reqs[u]    = make_req(pick, {lcg_draw(), lcg_draw()});
					// read back a fresh write now and then
					if (r[20]) begin
						rd = pick;
					end
				end
			end
		end
		r = lcg_draw();
		apply_cycle(reqs, (r[18:16] == 3'd0), phy_idx_t'(r >> 24), rd);
	endtask

	initial begin
		rst_n         = 1'b0;
		wb_req        = '0;
		log_clr_valid = 1'b0;
		log_clr_rd    = '0;
		rd_idx        = '0;
		lcg_state     = 32'h3e9b;
		model_log     = X0_MASK;
		for (int p = 0; p < `WB_PHY_NUM; p++) begin
			model_rf[p] = '0;
		end
		fill_rows();

		wait_edges(RST_CYCLES);
		rst_n = 1'b1;

		// state right after reset
		for (int p = 0; p < `WB_PHY_NUM; p++) begin
			apply_cycle('0, 1'b0, '0, phy_idx_t'(p));
		end

		// directed table
		for (int i = 0; i < NUM_ROWS; i++) begin
			apply_cycle(rows[i].reqs, rows[i].clr_valid, rows[i].clr_rd, rows[i].rd_idx);
			check_value("table rd_data", rd_data, rows[i].exp_data);
			check_value("table rd_written", rd_written, rows[i].exp_written);
		end

		// full sweep shows nothing else disturbed
		for (int p = 0; p < `WB_PHY_NUM; p++) begin
			apply_cycle('0, 1'b0, '0, phy_idx_t'(p));
		end

		for (int c = 0; c < RAND_CYCLES; c++) begin
			random_cycle();
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire
